//--- logic/fir_types_pkg.sv
/*
 * Datapath types for the symmetric FIR channel.
 * Sample and coefficient formats, the coefficient address and the
 * widths that grow through the pre-adders, multipliers and adder tree.
 */
`default_nettype none

package fir_types_pkg;

    // Q1.17 stream sample
    typedef logic signed [17:0] sample_t;

    // Q1.15 coefficient
    typedef logic signed [15:0] coef_t;

    // Index k weights taps k and 14-k, index 7 the centre tap
    typedef logic [2:0] coef_index_t;

    // Sum of a symmetric sample pair
    typedef logic signed [18:0] presum_t;

    // Full 18x18 product
    typedef logic signed [35:0] product_t;

    // Sum of eight products
    typedef logic signed [42:0] acc_t;

endpackage

`default_nettype wire

//--- logic/fir_config_pkg.sv
/*
 * Geometry and output scaling of the fifteen-tap linear-phase filter.
 * Pipeline depth is counted in advances from sample acceptance to the
 * output register.
 */
`default_nettype none

package fir_config_pkg;

    localparam int NUM_TAPS = 15;

    // Folded taps, one multiplier each
    localparam int NUM_COEFS = 8;

    localparam int PIPE_DEPTH = 6;

    // Accumulator bit that lands in output bit 0
    localparam int OUT_SHIFT = 16;

    // Symmetric clip levels
    localparam int SAT_POS = 131071;
    localparam int SAT_NEG = -131071;

endpackage

`default_nettype wire

//--- logic/coef_bank.sv
/*
 * Double-buffered coefficient store.
 * The host writes shadow registers one address per cycle, then a single
 * commit pulse copies the whole shadow set into the active set that the
 * filter multiplies with.
 */
`default_nettype none

module coef_bank (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       coef_we,
    input  wire fir_types_pkg::coef_index_t coef_addr,
    input  wire fir_types_pkg::coef_t       coef_data,
    input  wire logic                       coef_commit,
    output fir_types_pkg::coef_t            coef_active [fir_config_pkg::NUM_COEFS]
);
    import fir_types_pkg::*;
    import fir_config_pkg::*;

    coef_t shadow [NUM_COEFS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_COEFS; i++) begin
                shadow[i]      <= '0;
                coef_active[i] <= '0;
            end
        end else begin
            if (coef_we) begin
                shadow[coef_addr] <= coef_data;
            end
            // Snapshot of the old shadow set, a same-cycle write waits
            if (coef_commit) begin
                coef_active <= shadow;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/tap_multiplier.sv
/*
 * Registered signed 18x18 multiplier with clock enable.
 * Operands are captured on one enabled edge and the product on the next,
 * matching the hard multiplier core it models.
 */
`default_nettype none

module tap_multiplier (
    input  wire logic               clk,
    input  wire logic               en,
    input  wire logic signed [17:0] a,
    input  wire logic signed [17:0] b,
    output fir_types_pkg::product_t p
);

    logic signed [17:0] a_q;
    logic signed [17:0] b_q;

    always_ff @(posedge clk) begin
        if (en) begin
            a_q <= a;
            b_q <= b;
            p   <= a_q * b_q;
        end
    end

endmodule

`default_nettype wire

//--- logic/symmetric_fir.sv
/*
 * Fifteen-tap linear-phase FIR datapath.
 * Symmetric samples are pre-added and halved, multiplied by the active
 * coefficients and summed in a registered tree. The total is truncated
 * to the output format with symmetric saturation. Every register moves
 * only on advance.
 */
`default_nettype none

module symmetric_fir (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   advance,
    input  wire fir_types_pkg::sample_t in_data,
    input  wire fir_types_pkg::coef_t   coef_active [fir_config_pkg::NUM_COEFS],
    output fir_types_pkg::sample_t      out_data
);
    import fir_types_pkg::*;
    import fir_config_pkg::*;

    localparam int CENTER  = NUM_COEFS - 1;
    localparam int ACC_MSB = $bits(acc_t) - 1;
    localparam int TOP_LSB = OUT_SHIFT + $bits(sample_t) - 1;

    // delay[i] holds x[n-1-i] while x[n] sits on in_data
    sample_t            delay [NUM_TAPS - 1];
    presum_t            pair_sum [CENTER];
    logic signed [17:0] half_sum [NUM_COEFS];
    product_t           product [NUM_COEFS];
    acc_t               group_lo;
    acc_t               group_hi;
    acc_t               total;
    sample_t            data_bits;
    logic               over_pos;
    logic               over_neg;

    // History must start from zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_TAPS - 1; i++) begin
                delay[i] <= '0;
            end
        end else if (advance) begin
            delay[0] <= in_data;
            for (int i = 1; i < NUM_TAPS - 1; i++) begin
                delay[i] <= delay[i - 1];
            end
        end
    end

    always_comb begin
        pair_sum[0] = presum_t'(in_data) + presum_t'(delay[NUM_TAPS - 2]);
        for (int k = 1; k < CENTER; k++) begin
            pair_sum[k] = presum_t'(delay[k - 1]) + presum_t'(delay[NUM_TAPS - 2 - k]);
        end
        // Halve to fit the 18-bit multiplier port
        for (int k = 0; k < CENTER; k++) begin
            half_sum[k] = pair_sum[k][18:1];
        end
        half_sum[CENTER] = {delay[CENTER - 1][17], delay[CENTER - 1][17:1]};
    end

    for (genvar k = 0; k < NUM_COEFS; k++) begin : g_tap
        tap_multiplier u_mult (
            .clk (clk),
            .en  (advance),
            .a   (half_sum[k]),
            .b   ({coef_active[k], 2'b00}),
            .p   (product[k])
        );
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            group_lo <= acc_t'(product[0]) + acc_t'(product[1])
                      + acc_t'(product[2]) + acc_t'(product[3]);
            group_hi <= acc_t'(product[4]) + acc_t'(product[5])
                      + acc_t'(product[6]) + acc_t'(product[7]);
            total    <= group_lo + group_hi;

            // Top ten bits must all match the sign to fit
            data_bits <= total[TOP_LSB:OUT_SHIFT];
            over_pos  <= !total[ACC_MSB] && (total[ACC_MSB:TOP_LSB] != '0);
            over_neg  <= total[ACC_MSB] && (total[ACC_MSB:TOP_LSB] != '1);

            if (over_pos) begin
                out_data <= sample_t'(SAT_POS);
            end else if (over_neg) begin
                out_data <= sample_t'(SAT_NEG);
            end else begin
                out_data <= data_bits;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/stream_control.sv
/*
 * Valid/ready flow control around the filter pipeline.
 * An accepted sample is the only thing that advances the datapath, and a
 * valid bit travels alongside it so the first results after reset stay
 * hidden until the pipeline has filled.
 */
`default_nettype none

module stream_control (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic in_valid,
    input  wire logic out_ready,
    output logic      in_ready,
    output logic      advance,
    output logic      out_valid
);
    import fir_config_pkg::*;

    // Last pipeline stage is out_valid itself
    logic [PIPE_DEPTH-2:0] valid_sr;

    assign in_ready = !out_valid || out_ready;
    assign advance  = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr  <= '0;
            out_valid <= 1'b0;
        end else if (advance) begin
            valid_sr  <= {valid_sr[PIPE_DEPTH-3:0], 1'b1};
            out_valid <= valid_sr[PIPE_DEPTH-2];
        end else if (out_ready) begin
            // Taken with nothing behind it
            out_valid <= 1'b0;
        end
    end

    // A result under back-pressure stays presented
    out_valid_held_when_stalled: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid
    ) else $error("out_valid dropped under back-pressure");

    out_valid_rises_on_advance: assert property (
        @(posedge clk) disable iff (reset)
        !out_valid && !advance |=> !out_valid
    ) else $error("out_valid rose without an accepted sample");

endmodule

`default_nettype wire

//--- logic/fir_channel.sv
/*
 * Single-channel symmetric FIR with stream handshakes.
 * Samples enter on the input stream, results leave on the output stream,
 * and the host loads coefficients through the write and commit port.
 */
`default_nettype none

module fir_channel (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       in_valid,
    input  wire fir_types_pkg::sample_t     in_data,
    output logic                            in_ready,
    output logic                            out_valid,
    input  wire logic                       out_ready,
    output fir_types_pkg::sample_t          out_data,
    input  wire logic                       coef_we,
    input  wire fir_types_pkg::coef_index_t coef_addr,
    input  wire fir_types_pkg::coef_t       coef_data,
    input  wire logic                       coef_commit
);
    import fir_types_pkg::*;
    import fir_config_pkg::*;

    coef_t coef_active [NUM_COEFS];
    logic  advance;

    coef_bank u_coef_bank (
        .clk         (clk),
        .reset       (reset),
        .coef_we     (coef_we),
        .coef_addr   (coef_addr),
        .coef_data   (coef_data),
        .coef_commit (coef_commit),
        .coef_active (coef_active)
    );

    stream_control u_stream_control (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .advance   (advance),
        .out_valid (out_valid)
    );

    symmetric_fir u_symmetric_fir (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .in_data     (in_data),
        .coef_active (coef_active),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
/*
 * Free-running testbench clock, low at time zero.
 * The period is set by parameter, 40 ns by default.
 */
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- bench/fir_channel_tb.sv
/*
 * Testbench for the symmetric FIR channel.
 * Samples, handshakes and coefficient sets come from a fixed seed and every
 * result is checked bit-exactly against an integer model of the filter rule.
 * Inputs change 2 ns after the rising edge and are observed on the falling edge.
 */
`default_nettype none

module fir_channel_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fir_types_pkg::*;
    import fir_config_pkg::*;

    localparam int      SEND_LIMIT  = 20;
    localparam int      DRAIN_LIMIT = 20;
    localparam sample_t FULL_POS    = 131071;
    localparam sample_t FULL_NEG    = -131072;

    logic        clk;
    logic        reset;
    logic        in_valid;
    sample_t     in_data;
    logic        in_ready;
    logic        out_valid;
    logic        out_ready;
    sample_t     out_data;
    logic        coef_we;
    coef_index_t coef_addr;
    coef_t       coef_data;
    logic        coef_commit;

    // hist[k] is x[n-k] once sample n is accepted
    longint  hist [NUM_TAPS];
    coef_t   model_shadow [NUM_COEFS];
    coef_t   model_active [NUM_COEFS];
    longint  expected_q [$];
    int      error_count;
    int      timeout_count;
    int      accept_count;
    int      take_count;
    int      sat_pos_count;
    int      sat_neg_count;
    logic    model_valid;
    logic    last_accept;
    logic    prev_valid;
    logic    prev_advance;
    sample_t prev_data;

    clock_gen #(.PERIOD_NS(40)) u_clock_gen (.clk(clk));

    fir_channel dut (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .coef_we     (coef_we),
        .coef_addr   (coef_addr),
        .coef_data   (coef_data),
        .coef_commit (coef_commit)
    );

    function automatic longint floor_div(input longint num, input longint den);
        longint q;
        q = num / den;
        if ((num % den != 0) && ((num < 0) != (den < 0))) begin
            q = q - 1;
        end
        return q;
    endfunction

    function automatic longint filter_result();
        longint acc;
        longint half;
        longint r;
        acc = 0;
        for (int k = 0; k < NUM_COEFS; k++) begin
            if (k == NUM_COEFS - 1) begin
                half = floor_div(hist[k], 2);
            end else begin
                half = floor_div(hist[k] + hist[NUM_TAPS - 1 - k], 2);
            end
            acc += half * longint'(model_active[k]) * 4;
        end
        r = floor_div(acc, 65536);
        if (r < -131072 || r > 131071) begin
            r = (acc > 0) ? SAT_POS : SAT_NEG;
        end
        return r;
    endfunction

    // Falling-edge view of the cycle, applied to the model as the edge will
    task automatic observe();
        logic   accept;
        logic   take;
        longint expected;
        accept = in_valid && in_ready;
        take   = out_valid && out_ready;
        if (out_valid !== model_valid) begin
            error_count++;
            $display("ERROR at %0t: out_valid got %b expected %b", $time, out_valid,
                     model_valid);
        end
        if (in_ready !== (!model_valid || out_ready)) begin
            error_count++;
            $display("ERROR at %0t: in_ready got %b expected %b", $time, in_ready,
                     !model_valid || out_ready);
        end
        if (prev_valid && !prev_advance && out_valid && out_data !== prev_data) begin
            error_count++;
            $display("ERROR at %0t: out_data got %0d expected %0d while stalled", $time,
                     out_data, prev_data);
        end
        if (take && expected_q.size() == 0) begin
            error_count++;
            $display("A result was taken at %0t with no result expected", $time);
        end else if (take) begin
            expected = expected_q.pop_front();
            take_count++;
            sat_pos_count += (expected == SAT_POS);
            sat_neg_count += (expected == SAT_NEG);
            if (out_data !== sample_t'(expected)) begin
                error_count++;
                $display("ERROR at %0t: out_data got %0d expected %0d", $time, out_data,
                         expected);
            end
        end
        if (accept) begin
            for (int i = NUM_TAPS - 1; i > 0; i--) begin
                hist[i] = hist[i - 1];
            end
            hist[0] = longint'(in_data);
            expected_q.push_back(filter_result());
            accept_count++;
            // A result shows once the pipeline holds PIPE_DEPTH samples
            model_valid = (accept_count >= PIPE_DEPTH);
        end else if (out_ready) begin
            model_valid = 1'b0;
        end
        if (coef_commit) begin
            model_active = model_shadow;
        end
        if (coef_we) begin
            model_shadow[coef_addr] = coef_data;
        end
        last_accept  = accept;
        prev_valid   = out_valid;
        prev_advance = accept;
        prev_data    = out_data;
    endtask

    task automatic step(input logic valid, input sample_t data, input logic ready);
        in_valid  = valid;
        in_data   = data;
        out_ready = ready;
        @(negedge clk);
        observe();
        @(posedge clk);
        #2;
        coef_we     = 1'b0;
        coef_commit = 1'b0;
    endtask

    // out_ready stays low for the first hold_cycles, then waits for acceptance
    task automatic send_sample(input sample_t data, input int hold_cycles);
        int cycles;
        cycles      = 0;
        last_accept = 1'b0;
        while (!last_accept && cycles < hold_cycles + SEND_LIMIT) begin
            step(1'b1, data, cycles >= hold_cycles);
            cycles++;
        end
        if (!last_accept) begin
            timeout_count++;
            $display("Timed out at %0t waiting for a sample to be accepted", $time);
        end
    endtask

    task automatic write_coef(input coef_index_t addr, input coef_t data);
        coef_we   = 1'b1;
        coef_addr = addr;
        coef_data = data;
        step(1'b0, '0, 1'b1);
    endtask

    task automatic commit_coefs();
        coef_commit = 1'b1;
        step(1'b0, '0, 1'b1);
    endtask

    task automatic load_random_coefs();
        for (int k = 0; k < NUM_COEFS; k++) begin
            write_coef(coef_index_t'(k), coef_t'($urandom));
        end
        commit_coefs();
    endtask

    initial begin
        int cycles;
        void'($urandom(46));
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_data     = '0;
        out_ready   = 1'b0;
        coef_we     = 1'b0;
        coef_addr   = '0;
        coef_data   = '0;
        coef_commit = 1'b0;
        error_count = 0;
        timeout_count = 0;
        accept_count  = 0;
        take_count    = 0;
        sat_pos_count = 0;
        sat_neg_count = 0;
        model_valid   = 1'b0;
        last_accept   = 1'b0;
        prev_valid    = 1'b0;
        prev_advance  = 1'b0;
        prev_data     = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            hist[i] = 0;
        end
        for (int k = 0; k < NUM_COEFS; k++) begin
            model_shadow[k] = '0;
            model_active[k] = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        @(negedge clk);
        if (out_valid !== 1'b0) begin
            error_count++;
            $display("ERROR at %0t: out_valid got %b expected 0", $time, out_valid);
        end
        if (in_ready !== 1'b1) begin
            error_count++;
            $display("ERROR at %0t: in_ready got %b expected 1", $time, in_ready);
        end
        @(posedge clk);
        #2;

        // Pipeline fill with zero coefficients
        repeat (10) send_sample(sample_t'($urandom), 0);

        // Impulse among zeros
        load_random_coefs();
        repeat (14) send_sample('0, 0);
        send_sample(FULL_POS, 0);
        repeat (20) send_sample('0, 0);

        // Random handshakes on both streams
        load_random_coefs();
        repeat (400) begin
            step($urandom_range(0, 3) != 0, sample_t'($urandom), $urandom_range(0, 3) != 0);
        end

        // Clipping at both levels
        for (int k = 0; k < NUM_COEFS; k++) begin
            write_coef(coef_index_t'(k), 16'sd32767);
        end
        commit_coefs();
        repeat (30) send_sample(FULL_POS, 0);
        repeat (30) send_sample(FULL_NEG, 0);

        // Back-pressure stretches
        load_random_coefs();
        repeat (150) send_sample(sample_t'($urandom), $urandom_range(0, 6));

        // Shadow writes while streaming, then commits with the input idle
        load_random_coefs();
        repeat (20) send_sample(sample_t'($urandom), 0);
        for (int k = 0; k < NUM_COEFS; k++) begin
            coef_we   = 1'b1;
            coef_addr = coef_index_t'(k);
            coef_data = coef_t'($urandom);
            step(1'b1, sample_t'($urandom), 1'b1);
        end
        repeat (20) send_sample(sample_t'($urandom), 0);
        coef_we     = 1'b1;
        coef_addr   = 3'd3;
        coef_data   = coef_t'($urandom);
        coef_commit = 1'b1;
        step(1'b0, '0, 1'b1);
        repeat (30) send_sample(sample_t'($urandom), 0);
        commit_coefs();
        repeat (20) send_sample(sample_t'($urandom), 0);

        cycles = 0;
        while (out_valid && cycles < DRAIN_LIMIT) begin
            step(1'b0, '0, 1'b1);
            cycles++;
        end
        if (out_valid) begin
            timeout_count++;
            $display("Timed out at %0t waiting for the output to drain", $time);
        end
        if (expected_q.size() != PIPE_DEPTH - 1) begin
            error_count++;
            $display("%0d results still expected at the end, results were lost or repeated",
                     expected_q.size());
        end
        if (sat_pos_count == 0 || sat_neg_count == 0) begin
            error_count++;
            $display("Clipping reached only %0d positive and %0d negative results",
                     sat_pos_count, sat_neg_count);
        end

        $display("Accepted %0d samples, checked %0d results, %0d errors, %0d timeouts",
                 accept_count, take_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
logic/fir_types_pkg.sv
logic/fir_config_pkg.sv
logic/coef_bank.sv
logic/tap_multiplier.sv
logic/symmetric_fir.sv
logic/stream_control.sv
logic/fir_channel.sv
bench/clock_gen.sv
bench/fir_channel_tb.sv
